// ==== flist.f ====
+incdir+sim
source/rv_pkg.sv
source/pipe_ctrl.sv
source/fetch_unit.sv
source/instr_decoder.sv
source/reg_file.sv
source/exec_unit.sv
source/rv_core.sv
sim/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# build the core with its testbench, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f flist.f -o tb_rv_core

# the simulator exits nonzero on failure, the search below decides the result
out=$(./obj_dir/tb_rv_core 2>&1) || true
printf '%s\n' "$out"

echo "$out" | grep -q "TEST RESULT: PASS"

// ==== sim/iss_model.svh ====
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

// --------------------
// random source
// --------------------
logic [31:0] lfsr_state;

// one galois step, returns the bit shifted out
function automatic logic lfsr_step();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out_bit ? 32'h8020_0003 : 32'h0);
    return out_bit;
endfunction

// n fresh bits, msb first
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val = {val[30:0], lfsr_step()};
    end
    return val;
endfunction

// --------------------
// architectural model
// --------------------
logic [31:0] arch_regs [32];
logic [31:0] arch_pc;

function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101: begin
            if (alt) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic void reset_model();
    arch_regs = '{default: '0};
    arch_pc   = reset_pc;
endfunction

// executes one instruction and returns what it should retire
function automatic retire_t step_model();
    retire_t     want;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] next_pc;

    // memory wraps every 256 words
    ins     = prog_mem[arch_pc[9:2]];
    a       = arch_regs[ins[19:15]];
    b       = arch_regs[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    next_pc = arch_pc + 32'd4;

    want.pc   = arch_pc;
    want.rd   = ins[11:7];
    want.we   = 1'b1;
    want.data = '0;

    case (ins[6:0])
        7'b0110011: want.data = alu_calc(ins[14:12], ins[30], a, b);
        7'b0010011: want.data = alu_calc(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, imm_i);
        7'b0110111: want.data = {ins[31:12], 12'b0};
        7'b1101111: begin
            want.data = arch_pc + 32'd4;
            next_pc   = arch_pc + imm_j;
        end
        default: begin
            // conditional branch, the only other encoding in the program
            want.we = 1'b0;
            if (branch_taken(ins[14:12], a, b)) begin
                next_pc = arch_pc + imm_b;
            end
        end
    endcase

    // x0 stays zero
    if (want.we && want.rd != 5'd0) begin
        arch_regs[want.rd] = want.data;
    end
    arch_pc = next_pc;
    return want;
endfunction

`endif

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    localparam int          mem_words      = 256;
    localparam int          num_retire     = 2000;
    localparam int          timeout_cycles = 50;
    localparam logic [31:0] lfsr_seed      = 32'h2cac_0c1b;

    logic            clk;
    logic            rst;
    logic [xlen-1:0] imem_data;
    logic [xlen-1:0] imem_addr;
    logic            retire_valid;
    retire_t         retire;

    logic [31:0] prog_mem [mem_words];

    `include "iss_model.svh"

    rv_core UUT (
        .clk          (clk),
        .rst          (rst),
        .imem_data    (imem_data),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fetch address taken modulo the memory depth
    assign imem_data = prog_mem[imem_addr[9:2]];

    // --------------------
    // program generation
    // --------------------

    // half the picks come from x0..x7 so that dependencies are frequent
    function automatic logic [4:0] pick_reg();
        if (rand_bits(1) != 0) return 5'(rand_bits(3));
        return 5'(rand_bits(5));
    endfunction

    // nonzero word offset from -3 to +12
    function automatic logic [31:0] jump_offset();
        int words;
        words = int'(rand_bits(4)) - 3;
        if (words == 0) words = 1;
        return 32'(words * 4);
    endfunction

    // odd registers from lui, even ones from addi on x0
    function automatic logic [31:0] init_instr(input logic [4:0] rd);
        logic [19:0] upper;
        logic [11:0] imm;
        upper = 20'(rand_bits(20));
        imm   = 12'(rand_bits(12));
        if (rd[0]) return {upper, rd, 7'b0110111};
        return {imm, 5'd0, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [2:0]  kind;
        logic        alt;
        logic [11:0] imm;
        logic [31:0] off;
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        f3   = 3'(rand_bits(3));
        kind = 3'(rand_bits(3));
        alt  = rand_bits(1) != 0;
        imm  = 12'(rand_bits(12));
        case (kind)
            3'd0, 3'd1: begin
                // sub and sra are the only alternate forms
                if (alt && (f3 == 3'b000 || f3 == 3'b101)) begin
                    return {7'b0100000, rs2, rs1, f3, rd, 7'b0110011};
                end
                return {7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
            end
            3'd2, 3'd3: begin
                if (f3 == 3'b001) imm[11:5] = 7'b0000000;
                if (f3 == 3'b101) imm[11:5] = alt ? 7'b0100000 : 7'b0000000;
                return {imm, rs1, f3, rd, 7'b0010011};
            end
            3'd4: return {20'(rand_bits(20)), rd, 7'b0110111};
            3'd5, 3'd6: begin
                // funct3 010 and 011 are no branches
                if (f3[2:1] == 2'b01) f3 = f3 ^ 3'b110;
                off = jump_offset();
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
            end
            default: begin
                off = jump_offset();
                return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            end
        endcase
    endfunction

    function automatic void fill_program();
        for (int i = 0; i < mem_words; i++) begin
            if (i < 31) prog_mem[8'(i)] = init_instr(5'(i + 1));
            else prog_mem[8'(i)] = random_instr();
        end
    endfunction

    // --------------------
    // checking
    // --------------------
    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic wait_retire();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!retire_valid && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        assert (retire_valid) else begin
            $display("no instruction retired within %0d cycles", timeout_cycles);
            abort_run();
        end
    endtask

    task automatic compare_retire(input retire_t want);
        assert (retire.pc == want.pc) else begin
            $display("FAIL retire.pc got %h expected %h", retire.pc, want.pc);
            abort_run();
        end
        assert (retire.we == want.we) else begin
            $display("FAIL retire.we got %h expected %h at pc %h", retire.we, want.we, want.pc);
            abort_run();
        end
        // rd and data only matter for a register write
        if (want.we) begin
            assert (retire.rd == want.rd) else begin
                $display("FAIL retire.rd got %h expected %h at pc %h",
                         retire.rd, want.rd, want.pc);
                abort_run();
            end
            assert (retire.data == want.data) else begin
                $display("FAIL retire.data got %h expected %h at pc %h",
                         retire.data, want.data, want.pc);
                abort_run();
            end
        end
    endtask

    initial begin
        retire_t want;
        rst        = 1'b1;
        lfsr_state = lfsr_seed;
        fill_program();
        reset_model();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < num_retire; n++) begin
            wait_retire();
            want = step_model();
            compare_retire(want);
        end
        $display("%0d retirements matched the model", num_retire);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [rv_pkg::xlen-1:0] imem_data,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    output logic                    retire_valid,
    output rv_pkg::retire_t         retire
);
    import rv_pkg::*;

    fd_stage_t             fd;
    de_stage_t             de;
    retire_t               wb;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [reg_addr_w-1:0] ex_rs1;
    logic [reg_addr_w-1:0] ex_rs2;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       redirect_pc;
    logic                  redirect;
    logic                  dec_legal;
    logic                  de_valid;
    logic                  wb_valid;
    logic                  fwd_a;
    logic                  fwd_b;

    pipe_ctrl u_pipe_ctrl (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .dec_legal (dec_legal),
        .ex_rs1    (ex_rs1),
        .ex_rs2    (ex_rs2),
        .wb        (wb),
        .fd_valid  (),
        .de_valid  (de_valid),
        .wb_valid  (wb_valid),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b)
    );

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .fd          (fd)
    );

    instr_decoder u_instr_decoder (
        .fd       (fd),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .legal    (dec_legal),
        .de       (de)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .wb       (wb),
        .wb_valid (wb_valid),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit u_exec_unit (
        .clk         (clk),
        .rst         (rst),
        .de_valid_in (de_valid),
        .de_in       (de),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .wb_valid    (wb_valid),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb          (wb)
    );

    // retire report straight from write-back
    assign retire_valid = wb_valid;
    assign retire       = wb;

endmodule

`default_nettype wire

// ==== source/exec_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          de_valid_in,
    input  rv_pkg::de_stage_t             de_in,
    input  logic                          fwd_a,
    input  logic                          fwd_b,
    input  logic                          wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0] ex_rs1,
    output logic [rv_pkg::reg_addr_w-1:0] ex_rs2,
    output logic                          redirect,
    output logic [rv_pkg::xlen-1:0]       redirect_pc,
    output rv_pkg::retire_t               wb
);
    import rv_pkg::*;

    de_stage_t       de_q;
    retire_t         wb_q;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] rs2_fwd;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] result;
    logic            br_taken;

    // decode/execute register
    always_ff @(posedge clk) begin
        de_q <= de_in;
    end

    assign ex_rs1 = de_q.rs1;
    assign ex_rs2 = de_q.rs2;

    // --------------------
    // operands and alu
    // --------------------
    assign op_a    = fwd_a ? wb_q.data : de_q.rs1_val;
    assign rs2_fwd = fwd_b ? wb_q.data : de_q.rs2_val;
    assign op_b    = de_q.b_imm ? de_q.imm : rs2_fwd;

    always_comb begin
        case (de_q.alu_op)
            alu_sub:  alu_res = op_a - op_b;
            alu_and:  alu_res = op_a & op_b;
            alu_or:   alu_res = op_a | op_b;
            alu_xor:  alu_res = op_a ^ op_b;
            alu_slt:  alu_res = xlen'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_res = xlen'(op_a < op_b);
            alu_sll:  alu_res = op_a << op_b[4:0];
            alu_srl:  alu_res = op_a >> op_b[4:0];
            alu_sra:  alu_res = $signed(op_a) >>> op_b[4:0];
            default:  alu_res = op_a + op_b;
        endcase
    end

    // --------------------
    // branch and jump
    // --------------------
    always_comb begin
        case (de_q.br_cond)
            br_eq:   br_taken = (op_a == rs2_fwd);
            br_ne:   br_taken = (op_a != rs2_fwd);
            br_lt:   br_taken = ($signed(op_a) < $signed(rs2_fwd));
            br_ge:   br_taken = ($signed(op_a) >= $signed(rs2_fwd));
            br_ltu:  br_taken = (op_a < rs2_fwd);
            br_geu:  br_taken = (op_a >= rs2_fwd);
            default: br_taken = 1'b0;
        endcase
    end

    assign redirect    = de_valid_in & (de_q.jump | br_taken);
    assign redirect_pc = de_q.pc + de_q.imm;

    always_comb begin
        case (de_q.res_sel)
            res_pc4: result = de_q.pc + xlen'(4);
            res_imm: result = de_q.imm;
            default: result = alu_res;
        endcase
    end

    // write-back register
    always_ff @(posedge clk) begin
        wb_q.pc   <= de_q.pc;
        wb_q.rd   <= de_q.rd;
        wb_q.data <= result;
        if (rst) begin
            wb_q.we <= 1'b0;
        end else begin
            wb_q.we <= de_q.we;
        end
    end

    // write enable only counts for a live entry
    always_comb begin
        wb    = wb_q;
        wb.we = wb_q.we & wb_valid;
    end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  rv_pkg::retire_t               wb,
    input  logic                          wb_valid,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [rv_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pkg::xlen-1:0]       rs2_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];
    logic            wr_en;

    // x0 reads zero, same-cycle write wins over the array
    function automatic logic [xlen-1:0] rd_port(input logic [reg_addr_w-1:0] addr);
        if (addr == reg_addr_w'(0)) return '0;
        if (wr_en && wb.rd == addr) return wb.data;
        return regs[addr];
    endfunction

    assign wr_en = wb_valid & wb.we & (wb.rd != reg_addr_w'(0));

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = rd_port(rs1_addr);
    assign rs2_data = rd_port(rs2_addr);

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  rv_pkg::fd_stage_t             fd,
    input  logic [rv_pkg::xlen-1:0]       rs1_data,
    input  logic [rv_pkg::xlen-1:0]       rs2_data,
    output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    output logic                          legal,
    output rv_pkg::de_stage_t             de
);
    import rv_pkg::*;

    logic [xlen-1:0] ins;
    opcode_e         opc;
    logic [2:0]      funct3;
    logic [6:0]      funct7;

    // funct3 to alu op, alt picks sub or sra
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign ins    = fd.instr;
    assign opc    = opcode_e'(ins[6:0]);
    assign funct3 = ins[14:12];
    assign funct7 = ins[31:25];

    assign rs1_addr = ins[19:15];
    assign rs2_addr = ins[24:20];

    always_comb begin
        de         = '0;
        de.pc      = fd.pc;
        de.rs1     = rs1_addr;
        de.rs2     = rs2_addr;
        de.rd      = ins[11:7];
        de.rs1_val = rs1_data;
        de.rs2_val = rs2_data;
        de.alu_op  = alu_add;
        de.res_sel = res_alu;
        de.br_cond = br_none;
        legal      = 1'b0;

        case (opc)
            opc_op: begin
                de.alu_op = alu_sel(funct3, funct7[5]);
                de.we     = 1'b1;
                legal     = (funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            opc_op_imm: begin
                // I immediate
                de.imm    = {{20{ins[31]}}, ins[31:20]};
                de.b_imm  = 1'b1;
                de.alu_op = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
                de.we     = 1'b1;
                case (funct3)
                    3'b001:  legal = (funct7 == 7'b0000000);
                    3'b101:  legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    default: legal = 1'b1;
                endcase
            end
            opc_lui: begin
                de.imm     = {ins[31:12], 12'b0};
                de.res_sel = res_imm;
                de.we      = 1'b1;
                legal      = 1'b1;
            end
            opc_branch: begin
                de.imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                case (funct3)
                    3'b000:  de.br_cond = br_eq;
                    3'b001:  de.br_cond = br_ne;
                    3'b100:  de.br_cond = br_lt;
                    3'b101:  de.br_cond = br_ge;
                    3'b110:  de.br_cond = br_ltu;
                    default: de.br_cond = br_geu;
                endcase
                legal = (funct3 != 3'b010) && (funct3 != 3'b011);
            end
            opc_jal: begin
                de.imm     = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                de.jump    = 1'b1;
                de.res_sel = res_pc4;
                de.we      = 1'b1;
                legal      = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redirect,
    input  logic [rv_pkg::xlen-1:0] redirect_pc,
    input  logic [rv_pkg::xlen-1:0] imem_data,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    output rv_pkg::fd_stage_t       fd
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;

    // program counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else begin
            pc <= pc + xlen'(4);
        end
    end

    // instruction memory is read in the same cycle
    assign imem_addr = pc;

    // fetch/decode payload, validity lives in pipe_ctrl
    always_ff @(posedge clk) begin
        fd.pc    <= pc;
        fd.instr <= imem_data;
    end

endmodule

`default_nettype wire

// ==== source/pipe_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          redirect,
    input  logic                          dec_legal,
    input  logic [rv_pkg::reg_addr_w-1:0] ex_rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] ex_rs2,
    input  rv_pkg::retire_t               wb,
    output logic                          fd_valid,
    output logic                          de_valid,
    output logic                          wb_valid,
    output logic                          fwd_a,
    output logic                          fwd_b
);
    import rv_pkg::*;

    logic wb_writes;

    // --------------------
    // stage valid bits
    // --------------------

    // a taken transfer in execute kills fetch/decode and decode/execute
    always_ff @(posedge clk) begin
        if (rst) begin
            fd_valid <= 1'b0;
            de_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            fd_valid <= ~redirect;
            de_valid <= fd_valid & dec_legal & ~redirect;
            wb_valid <= de_valid;
        end
    end

    // --------------------
    // forwarding selects
    // --------------------
    assign wb_writes = wb_valid & wb.we & (wb.rd != reg_addr_w'(0));

    assign fwd_a = wb_writes & (wb.rd == ex_rs1);
    assign fwd_b = wb_writes & (wb.rd == ex_rs2);

endmodule

`default_nettype wire

// ==== source/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // --------------------
    // widths and constants
    // --------------------
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = '0;

    // --------------------
    // encodings
    // --------------------

    // major opcodes of the kept instruction set
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    // br_none marks a non-branch instruction
    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu
    } br_cond_e;

    // write-back value source
    typedef enum logic [1:0] {
        res_alu,
        res_pc4,
        res_imm
    } res_sel_e;

    // --------------------
    // stage payloads
    // --------------------
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } fd_stage_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rs1_val;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;
        alu_op_e               alu_op;
        logic                  b_imm;
        res_sel_e              res_sel;
        br_cond_e              br_cond;
        logic                  jump;
        logic                  we;
    } de_stage_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        logic                  we;
    } retire_t;

endpackage

`default_nettype wire
